// File: display_bank.sv
`include "loteria_params.svh"

module display_bank import lottery_pkg::*, seg7_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       fim,
   input  lot_state_t state,
   input  tally_t     tally,
   output seg_t       hex0,
   output seg_t       hex1,
   output seg_t       hex2,
   output seg_t       hex3,
   output seg_t       hex4,
   output seg_t       hex5,
   output seg_t       hex6,
   output seg_t       hex7
);

   seg_pair_t state_segs;
   seg_pair_t snap_first;    // Counts frozen at the last fim
   seg_pair_t snap_second;
   logic      snap_taken;

   ////////////////////////////////////////////////////////////
   // Live digits
   ////////////////////////////////////////////////////////////
   assign state_segs = seg_two_digit(seg_val_t'(state));
   assign hex2       = state_segs.ones;
   assign hex3       = state_segs.tens;

   // Outcome of the last closed game
   assign hex0 = tally.shown ? seg_digit(tally.result) : `LOT_SEG_BANNER0;
   assign hex1 = `LOT_SEG_BANNER1;

   ////////////////////////////////////////////////////////////
   // Score snapshot
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         snap_taken <= 1'b0;
      end else if (fim) begin
         snap_taken <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fim) begin
         snap_first  <= seg_two_digit(tally.first_cnt);
         snap_second <= seg_two_digit(tally.second_cnt);
      end
   end

   // Second prize on hex5:hex4, first prize on hex7:hex6
   assign hex4 = snap_taken ? snap_second.ones : `LOT_SEG_BANNER4;
   assign hex5 = snap_taken ? snap_second.tens : `LOT_SEG_BANNER5;
   assign hex6 = snap_taken ? snap_first.ones  : `LOT_SEG_BANNER6;
   assign hex7 = snap_taken ? snap_first.tens  : `LOT_SEG_BANNER7;

   // Digits only show loaded data
   a_digits_known: assert property (
      @(posedge clk) disable iff (reset)
      !$isunknown({hex0, hex2, hex3, hex4, hex5, hex6, hex7})
   );

endmodule

// File: loteria_params.svh
`ifndef LOTERIA_PARAMS_SVH
`define LOTERIA_PARAMS_SVH

// Keyed digit and game state widths
`define LOT_DIGIT_W     4
`define LOT_STATE_W     5
`define LOT_NUM_STATES  19    // States 0 to 18

// Win counters wrap from 31 to 0
`define LOT_CNT_W       5

`define LOT_MAX_DIGIT   9     // Larger keyed values are ignored

// Banner segment patterns, active low
`define LOT_SEG_BANNER0 7'b0111111
`define LOT_SEG_BANNER1 7'b0001100
`define LOT_SEG_BANNER4 7'b0100100
`define LOT_SEG_BANNER5 7'b0001100
`define LOT_SEG_BANNER6 7'b1111001
`define LOT_SEG_BANNER7 7'b0001100

`endif

// File: loteria_top.f
+incdir+.
lottery_pkg.sv
seg7_pkg.sv
ticket_fsm.sv
prize_tally.sv
display_bank.sv
loteria_top.sv
tb_loteria.sv

// File: loteria_top.sv
module loteria_top import lottery_pkg::*, seg7_pkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  digit_t num,
   input  logic   insere,
   input  logic   fim_jogo,
   input  logic   fim,
   output seg_t   hex0,
   output seg_t   hex1,
   output seg_t   hex2,
   output seg_t   hex3,
   output seg_t   hex4,
   output seg_t   hex5,
   output seg_t   hex6,
   output seg_t   hex7
);

   lot_state_t state;
   prize_t     prize;
   tally_t     tally;

   ticket_fsm fsm0 (
      .clk      (clk),
      .reset    (reset),
      .num      (num),
      .insere   (insere),
      .fim_jogo (fim_jogo),
      .fim      (fim),
      .state    (state),
      .prize    (prize)
   );

   prize_tally tally0 (
      .clk      (clk),
      .reset    (reset),
      .fim_jogo (fim_jogo),
      .prize    (prize),
      .tally    (tally)
   );

   display_bank disp0 (
      .clk   (clk),
      .reset (reset),
      .fim   (fim),
      .state (state),
      .tally (tally),
      .hex0  (hex0),
      .hex1  (hex1),
      .hex2  (hex2),
      .hex3  (hex3),
      .hex4  (hex4),
      .hex5  (hex5),
      .hex6  (hex6),
      .hex7  (hex7)
   );

endmodule

// File: lottery_pkg.sv
`include "loteria_params.svh"

package lottery_pkg;

   typedef logic [`LOT_DIGIT_W-1:0] digit_t;
   typedef logic [`LOT_STATE_W-1:0] lot_state_t;
   typedef logic [`LOT_CNT_W-1:0]   cnt_t;

   ////////////////////////////////////////////////////////////
   // Named states of the decision tree
   ////////////////////////////////////////////////////////////
   localparam lot_state_t ST_IDLE   = lot_state_t'(0);
   localparam lot_state_t ST_START  = lot_state_t'(1);
   localparam lot_state_t ST_FIRST  = lot_state_t'(16);  // First prize
   localparam lot_state_t ST_NONE   = lot_state_t'(17);
   localparam lot_state_t ST_SECOND = lot_state_t'(18);  // Second prize

   // Outcome of the current ticket
   typedef enum logic [1:0] {
      PRIZE_PENDING,
      PRIZE_NONE,
      PRIZE_FIRST,
      PRIZE_SECOND
   } prize_t;

   ////////////////////////////////////////////////////////////
   // Game results
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      logic   shown;       // Some outcome latched since reset
      digit_t result;      // 0, 1 or 2
      cnt_t   first_cnt;
      cnt_t   second_cnt;
   } tally_t;

endpackage

// File: prize_tally.sv
module prize_tally import lottery_pkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  logic   fim_jogo,
   input  prize_t prize,
   output tally_t tally
);

   cnt_t   first_cnt;
   cnt_t   second_cnt;
   logic   shown;
   digit_t result;

   // Counters and the valid flag
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         first_cnt  <= '0;
         second_cnt <= '0;
         shown      <= 1'b0;
      end else if (fim_jogo && prize != PRIZE_PENDING) begin
         shown <= 1'b1;
         if (prize == PRIZE_FIRST) first_cnt <= first_cnt + 1'b1;    // Wraps at 31
         if (prize == PRIZE_SECOND) second_cnt <= second_cnt + 1'b1;
      end
   end

   // Outcome digit, qualified by shown
   always_ff @(posedge clk) begin
      if (fim_jogo) begin
         case (prize)
            PRIZE_FIRST:  result <= digit_t'(1);
            PRIZE_SECOND: result <= digit_t'(2);
            PRIZE_NONE:   result <= digit_t'(0);
            default:      result <= result;
         endcase
      end
   end

   assign tally = '{shown:      shown,
                    result:     result,
                    first_cnt:  first_cnt,
                    second_cnt: second_cnt};

   // A game ends with at most one win
   a_one_win: assert property (
      @(posedge clk) disable iff (reset)
      !($changed(tally.first_cnt) && $changed(tally.second_cnt)) &&
      (!$changed(tally.first_cnt) ||
       tally.first_cnt == cnt_t'($past(tally.first_cnt) + 1)) &&
      (!$changed(tally.second_cnt) ||
       tally.second_cnt == cnt_t'($past(tally.second_cnt) + 1))
   );

endmodule

// File: seg7_pkg.sv
`include "loteria_params.svh"

package seg7_pkg;

   // Active low, bit 0 is segment a
   typedef logic [6:0] seg_t;

   typedef struct packed {
      seg_t tens;
      seg_t ones;
   } seg_pair_t;

   typedef logic [`LOT_CNT_W-1:0] seg_val_t;   // Two-digit value, 0 to 31

   localparam seg_t SEG_BLANK = 7'b1111111;

   ////////////////////////////////////////////////////////////
   // Decoders
   ////////////////////////////////////////////////////////////
   function automatic seg_t seg_digit(input logic [`LOT_DIGIT_W-1:0] d);
      seg_t s;
      case (d)
         4'd0:    s = 7'b1000000;
         4'd1:    s = 7'b1111001;
         4'd2:    s = 7'b0100100;
         4'd3:    s = 7'b0110000;
         4'd4:    s = 7'b0011001;
         4'd5:    s = 7'b0010010;
         4'd6:    s = 7'b0000010;
         4'd7:    s = 7'b1111000;
         4'd8:    s = 7'b0000000;
         4'd9:    s = 7'b0010000;
         default: s = SEG_BLANK;   // Not a decimal digit
      endcase
      return s;
   endfunction

   function automatic seg_pair_t seg_two_digit(input seg_val_t v);
      seg_pair_t                p;
      logic [`LOT_DIGIT_W-1:0]  tens;
      logic [`LOT_DIGIT_W-1:0]  ones;
      tens   = (`LOT_DIGIT_W)'(v / 10);
      ones   = (`LOT_DIGIT_W)'(v % 10);
      p.tens = seg_digit(tens);
      p.ones = seg_digit(ones);
      return p;
   endfunction

endpackage

// File: tb_loteria.sv
`include "loteria_params.svh"

module tb_loteria;

   localparam int NUM_GAMES  = 120;
   localparam int MAX_CYCLES = 40 * NUM_GAMES + 100;

   // Decision tree by state, want of -1 means any digit
   localparam int TREE_WANT [16] = '{-1, 5, 7, 7, 9, 9, 9, 3, -1, 3, -1, 3, -1, 6, 6, -1};
   localparam int TREE_HIT  [16] = '{0, 2, 4, 6, 7, 9, 11, 12, 14, 14, 15, 13, 16, 16, 18, 17};
   localparam int TREE_MISS [16] = '{0, 3, 5, 5, 8, 10, 10, 13, 14, 15, 15, 14, 16, 17, 17, 17};

   logic       clk;
   logic       reset;
   logic [3:0] num;
   logic       insere;
   logic       fim_jogo;
   logic       fim;
   logic [6:0] hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;

   int          errors;
   int          test_errors;
   int          tests_ok;
   int          tests_bad;
   int          cycles;
   logic [15:0] lfsr;

   // Reference model
   int          model_state;
   logic        model_shown;
   int          model_result;
   logic [4:0]  model_first;
   logic [4:0]  model_second;
   logic        model_snap_taken;
   logic [4:0]  model_snap_first;
   logic [4:0]  model_snap_second;

   loteria_top dut0 (
      .clk(clk), .reset(reset), .num(num), .insere(insere), .fim_jogo(fim_jogo), .fim(fim),
      .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
      .hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7)
   );

   always #10 clk = ~clk;

   function automatic logic [6:0] seg_of(input int d);
      logic [6:0] s;
      case (d)
         0:       s = 7'b1000000;
         1:       s = 7'b1111001;
         2:       s = 7'b0100100;
         3:       s = 7'b0110000;
         4:       s = 7'b0011001;
         5:       s = 7'b0010010;
         6:       s = 7'b0000010;
         7:       s = 7'b1111000;
         8:       s = 7'b0000000;
         9:       s = 7'b0010000;
         default: s = 7'b1111111;
      endcase
      return s;
   endfunction

   function automatic int tree_next(input int s, input int d);
      if (s > 15) return s;                    // Terminal states hold
      if (TREE_WANT[s] < 0 || TREE_WANT[s] == d) return TREE_HIT[s];
      return TREE_MISS[s];
   endfunction

   ////////////////////////////////////////////////////////////
   // Random digits
   ////////////////////////////////////////////////////////////
   function automatic int draw(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         v    = (v << 1) | lfsr[0];
      end
      return v;
   endfunction

   function automatic int rand_digit();
      int v;
      v = draw(4);
      if (v > 9) v = v - 6;
      return v;
   endfunction

   function automatic int rand_other(input int avoid);
      int d;
      d = rand_digit();
      if (d == avoid) d = (d + 1) % 10;
      return d;
   endfunction

   always @(posedge clk or posedge reset) begin
      if (reset) begin
         model_state      <= 1;
         model_shown      <= 1'b0;
         model_result     <= 0;
         model_first      <= '0;
         model_second     <= '0;
         model_snap_taken <= 1'b0;
      end else if (fim) begin
         model_state       <= 0;
         model_snap_taken  <= 1'b1;
         model_snap_first  <= model_first;
         model_snap_second <= model_second;
      end else if (fim_jogo) begin
         model_state <= 1;
         if (model_state == 16) begin
            model_first  <= model_first + 1'b1;
            model_result <= 1;
         end
         if (model_state == 18) begin
            model_second <= model_second + 1'b1;
            model_result <= 2;
         end
         if (model_state == 17) model_result <= 0;
         if (model_state >= 16) model_shown <= 1'b1;
      end else if (insere && num <= `LOT_MAX_DIGIT) begin
         model_state <= tree_next(model_state, num);
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks against the model
   ////////////////////////////////////////////////////////////
   a_state_digits: assert property (@(posedge clk) disable iff (reset)
      hex3 == seg_of(model_state / 10) && hex2 == seg_of(model_state % 10))
   else begin
      $display("Mismatch at %0t: state digits differ, model state %0d",
               $time, $sampled(model_state));
      errors++;
   end

   a_outcome: assert property (@(posedge clk) disable iff (reset)
      hex0 == (model_shown ? seg_of(model_result) : `LOT_SEG_BANNER0))
   else begin
      $display("Mismatch at %0t: outcome digit on hex0 is %b", $time, $sampled(hex0));
      errors++;
   end

   a_label: assert property (@(posedge clk) hex1 == `LOT_SEG_BANNER1)
   else begin
      $display("Mismatch at %0t: hex1 left its banner", $time);
      errors++;
   end

   a_scores: assert property (@(posedge clk) disable iff (reset)
      model_snap_taken ?
         (hex4 == seg_of(model_snap_second % 10) && hex5 == seg_of(model_snap_second / 10) &&
          hex6 == seg_of(model_snap_first % 10) && hex7 == seg_of(model_snap_first / 10)) :
         (hex4 == `LOT_SEG_BANNER4 && hex5 == `LOT_SEG_BANNER5 &&
          hex6 == `LOT_SEG_BANNER6 && hex7 == `LOT_SEG_BANNER7))
   else begin
      $display("Mismatch at %0t: score digits, model counts %0d and %0d", $time,
               $sampled(model_snap_first), $sampled(model_snap_second));
      errors++;
   end

   // Each task starts and ends on a falling edge
   task apply_key(input int d);
      num    = d[3:0];
      insere = 1'b1;
      @(negedge clk);
      insere = 1'b0;
   endtask

   task end_game();
      fim_jogo = 1'b1;
      @(negedge clk);
      fim_jogo = 1'b0;
   endtask

   task show_scores();
      fim = 1'b1;
      @(negedge clk);
      fim = 1'b0;
   endtask

   task check_state(input int s);
      assert (hex3 == seg_of(s / 10) && hex2 == seg_of(s % 10))
      else begin
         $display("Mismatch at %0t: state digits %b %b, expected %0d", $time, hex3, hex2, s);
         errors++;
      end
   endtask

   task check_hex0(input logic [6:0] want);
      assert (hex0 == want)
      else begin
         $display("Mismatch at %0t: hex0 is %b, expected %b", $time, hex0, want);
         errors++;
      end
   endtask

   task finish_test(input string name);
      if (errors == test_errors) tests_ok++;
      else tests_bad++;
      $display("Test %s done with %0d errors", name, errors - test_errors);
      test_errors = errors;
   endtask

   task play_first_prize();
      apply_key(5);
      apply_key(7);
      apply_key(9);
      apply_key(3);
      apply_key(rand_digit());
      end_game();
   endtask

   task play_second_prize();
      apply_key(5);
      apply_key(7);
      apply_key(rand_other(9));
      apply_key(rand_digit());
      apply_key(6);
      end_game();
   endtask

   task play_random_game();
      int want;
      repeat (5) begin
         want = (model_state <= 15) ? TREE_WANT[model_state] : -1;
         if (draw(3) == 0) apply_key(10 + draw(2));     // Ignored digit
         else if (draw(1) == 1 && want >= 0) apply_key(want);
         else apply_key(rand_digit());
      end
      end_game();
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("*** FAILED ***");
         $finish;
      end
   end

   initial begin
      clk         = 0;
      reset       = 1;
      num         = '0;
      insere      = 0;
      fim_jogo    = 0;
      fim         = 0;
      errors      = 0;
      test_errors = 0;
      tests_ok    = 0;
      tests_bad   = 0;
      cycles      = 0;
      lfsr        = 16'd50653;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 0;
      @(negedge clk);
      check_state(1);
      check_hex0(`LOT_SEG_BANNER0);
      finish_test("reset");

      play_first_prize();
      check_hex0(seg_of(1));
      check_state(1);
      apply_key(5);
      apply_key(rand_other(7));
      apply_key(9);
      apply_key(3);
      check_state(14);
      apply_key(6);
      check_state(18);
      end_game();
      check_hex0(seg_of(2));
      finish_test("ticket paths");

      apply_key(5);
      for (int d = 10; d <= 15; d++) begin
         apply_key(d);
         check_state(2);
      end
      apply_key(rand_other(7));
      apply_key(rand_other(9));
      apply_key(rand_digit());
      apply_key(rand_digit());
      check_state(17);
      finish_test("invalid digits");

      end_game();
      check_hex0(seg_of(0));
      check_state(1);
      play_first_prize();
      check_hex0(seg_of(1));
      apply_key(5);
      end_game();
      check_hex0(seg_of(1));                        // Pending game leaves hex0 alone
      check_state(1);
      finish_test("game close");

      repeat (40) play_random_game();
      show_scores();
      check_state(0);
      apply_key(5);
      check_state(0);
      end_game();
      check_state(1);
      for (int i = 0; i < 34; i++) begin
         play_first_prize();
         play_second_prize();
      end
      show_scores();
      @(negedge clk);
      check_state(0);
      finish_test("scores");

      $display("Tests: %0d ok, %0d with errors, %0d errors in total", tests_ok, tests_bad, errors);
      if (tests_bad == 0 && errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: ticket_fsm.sv
`include "loteria_params.svh"

module ticket_fsm import lottery_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  digit_t     num,
   input  logic       insere,
   input  logic       fim_jogo,
   input  logic       fim,
   output lot_state_t state,
   output prize_t     prize
);

   logic digit_ok;

   ////////////////////////////////////////////////////////////
   // Decision tree
   ////////////////////////////////////////////////////////////

   // One comparison node: match on want, else take the other branch
   function automatic lot_state_t branch(
      input digit_t      d,
      input int unsigned want,
      input int unsigned on_hit,
      input int unsigned on_miss
   );
      lot_state_t nxt;
      if (d == digit_t'(want)) begin
         nxt = lot_state_t'(on_hit);
      end else begin
         nxt = lot_state_t'(on_miss);
      end
      return nxt;
   endfunction

   function automatic lot_state_t tree_step(input lot_state_t s, input digit_t d);
      lot_state_t nxt;
      case (s)
         ST_IDLE,
         ST_FIRST,
         ST_NONE,
         ST_SECOND: nxt = s;                         // Parked until fim_jogo
         1:         nxt = branch(d, 5, 2, 3);
         2:         nxt = branch(d, 7, 4, 5);
         3:         nxt = branch(d, 7, 6, 5);
         4:         nxt = branch(d, 9, 7, 8);
         5:         nxt = branch(d, 9, 9, 10);
         6:         nxt = branch(d, 9, 11, 10);
         7:         nxt = branch(d, 3, 12, 13);
         8:         nxt = lot_state_t'(14);          // Any digit
         9:         nxt = branch(d, 3, 14, 15);
         10:        nxt = lot_state_t'(15);
         11:        nxt = branch(d, 3, 13, 14);
         12:        nxt = ST_FIRST;
         13:        nxt = branch(d, 6, 16, 17);
         14:        nxt = branch(d, 6, 18, 17);
         15:        nxt = ST_NONE;
         default:   nxt = ST_IDLE;                   // Unused codes
      endcase
      return nxt;
   endfunction

   assign digit_ok = (num <= digit_t'(`LOT_MAX_DIGIT));

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= ST_START;
      end else if (fim) begin
         state <= ST_IDLE;
      end else if (fim_jogo) begin
         state <= ST_START;                          // New ticket
      end else if (insere && digit_ok) begin
         state <= tree_step(state, num);
      end
   end

   ////////////////////////////////////////////////////////////
   // Outcome from the terminal state
   ////////////////////////////////////////////////////////////
   always_comb begin
      case (state)
         ST_FIRST:  prize = PRIZE_FIRST;
         ST_NONE:   prize = PRIZE_NONE;
         ST_SECOND: prize = PRIZE_SECOND;
         default:   prize = PRIZE_PENDING;
      endcase
   end

   // No sequence of inputs leaves the tree
   a_state_range: assert property (
      @(posedge clk) disable iff (reset)
      state < `LOT_NUM_STATES
   );

endmodule
